// ==== sources.f ====
+incdir+.
syscfg_bus_pkg.sv
syscfg_tgt_pkg.sv
syscfg_reg_if.sv
syscfg_wb_decoder.sv
syscfg_tgt.sv
syscfg_top.sv
tb_syscfg.sv

// ==== tb_syscfg.sv ====
`include "syscfg_consts.svh"
`timescale 1ns/1ps

module tb_syscfg
    import syscfg_bus_pkg::*;
();

    localparam int RST_CYCLES   = 3;
    localparam int ACC_CYCLES   = 3;  // Request, ack, release
    localparam int IRQ_ROUNDS   = 8;
    localparam int EST_ACCESSES = 36 + 28 + 4 + 7 * IRQ_ROUNDS + 8;
    // Margin covers the pause waits and idle gaps
    localparam int MAX_CYCLES   = 4 * (RST_CYCLES + ACC_CYCLES * EST_ACCESSES + 100);

    logic                       clk = 1'b0;
    logic                       rst_n;
    logic                       cyc;
    logic                       stb;
    logic                       we;
    addr_t                      adr;
    data_t                      dat_w;
    data_t                      dat_r;
    logic                       ack;
    data_t                      irq_vec = '0;
    logic [`SYSCFG_NO_TGTS-1:0] tgt_pause_ack = '0;
    logic [`SYSCFG_NO_TGTS-1:0] tgt_rst;
    logic [`SYSCFG_NO_TGTS-1:0] tgt_pause_req;
    addr_t                      cpu_boot_addr;
    logic                       cpu_irq;
    logic                       dma_irq;

    // Expected register state
    logic [`SYSCFG_NO_TGTS-1:0] exp_rst;
    logic [`SYSCFG_NO_TGTS-1:0] exp_pause;
    addr_t                      exp_boot;
    data_t                      cpu_mask;
    data_t                      dma_mask;

    data_t  last_rd;
    int     ack_wait [`SYSCFG_NO_TGTS];
    int     ack_delay;
    int     cycle_cnt = 0;
    integer seed = 32'h71c0;
    string  test_name = "reset";

    syscfg_top syscfg_top_inst (.*);

    always #20 clk = ~clk;

    task automatic stop_on_error();
        $display("Test failed");
        $fatal(1, "stopped at the first error");
    endtask

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("timeout in %s after %0d cycles", test_name, cycle_cnt);
            stop_on_error();
        end
    end

    // Target model and random interrupt sources
    always @(posedge clk) begin
        irq_vec <= $random(seed) & $random(seed);
        for (int i = 0; i < `SYSCFG_NO_TGTS; i++) begin
            if (!tgt_pause_req[i]) begin
                tgt_pause_ack[i] <= 1'b0;
                ack_wait[i]      <= 0;
            end
            else if (!tgt_pause_ack[i]) begin
                if (ack_wait[i] == 0) begin
                    ack_delay = 1 + ($unsigned($random(seed)) % 4);
                    if (ack_delay == 1)
                        tgt_pause_ack[i] <= 1'b1;
                    else
                        ack_wait[i] <= ack_delay - 1;
                end
                else if (ack_wait[i] == 1)
                    tgt_pause_ack[i] <= 1'b1;
                else
                    ack_wait[i] <= ack_wait[i] - 1;
            end
        end
    end

    rst_chk: assert property (@(posedge clk) disable iff (!rst_n) tgt_rst == exp_rst)
        else begin
            $display("mismatch %s expected %b actual %b", test_name,
                     $sampled(exp_rst), $sampled(tgt_rst));
            stop_on_error();
        end

    pause_chk: assert property (@(posedge clk) disable iff (!rst_n) tgt_pause_req == exp_pause)
        else begin
            $display("mismatch %s expected %b actual %b", test_name,
                     $sampled(exp_pause), $sampled(tgt_pause_req));
            stop_on_error();
        end

    boot_chk: assert property (@(posedge clk) disable iff (!rst_n) cpu_boot_addr == exp_boot)
        else begin
            $display("mismatch %s expected %h actual %h", test_name,
                     $sampled(exp_boot), $sampled(cpu_boot_addr));
            stop_on_error();
        end

    cpu_irq_chk: assert property (@(posedge clk) disable iff (!rst_n)
                                  cpu_irq == |(irq_vec & cpu_mask))
        else begin
            $display("mismatch %s expected %b actual %b", test_name,
                     |($sampled(irq_vec) & $sampled(cpu_mask)), $sampled(cpu_irq));
            stop_on_error();
        end

    dma_irq_chk: assert property (@(posedge clk) disable iff (!rst_n)
                                  dma_irq == |(irq_vec & dma_mask))
        else begin
            $display("mismatch %s expected %b actual %b", test_name,
                     |($sampled(irq_vec) & $sampled(dma_mask)), $sampled(dma_irq));
            stop_on_error();
        end

    function automatic addr_t reg_addr(int idx, reg_off_t off);
        return addr_t'({idx[2:0], off, 2'b00});
    endfunction

    function automatic data_t sparse_word();
        return $random(seed) & $random(seed) & $random(seed);
    endfunction

    function automatic void apply_write(addr_t a, data_t d);
        int idx;
        idx = a[6:4];
        if (idx >= `SYSCFG_NO_TGTS)
            return;
        case (reg_off_t'(a[3:2]))
            REG_CTRL: begin
                exp_rst[idx]   = d[0];
                exp_pause[idx] = d[1];
            end
            REG_BOOT:
                if (idx == `SYSCFG_TGT_CPU0) exp_boot = d;
            REG_IRQ_MASK: begin
                if (idx == `SYSCFG_TGT_CPU0) cpu_mask = d;
                if (idx == `SYSCFG_TGT_DMA0) dma_mask = d;
            end
            default: ;  // STATUS is read only
        endcase
    endfunction

    function automatic data_t expected_read(addr_t a);
        int idx;
        idx = a[6:4];
        if (idx >= `SYSCFG_NO_TGTS)
            return '0;
        case (reg_off_t'(a[3:2]))
            REG_CTRL:     return data_t'({exp_pause[idx], exp_rst[idx]});
            REG_STATUS:   return data_t'(exp_pause[idx] & tgt_pause_ack[idx]);
            REG_BOOT:     return (idx == `SYSCFG_TGT_CPU0) ? exp_boot : '0;
            default: begin
                if (idx == `SYSCFG_TGT_CPU0) return cpu_mask;
                if (idx == `SYSCFG_TGT_DMA0) return dma_mask;
                return '0;
            end
        endcase
    endfunction

    task automatic wb_cycle(input logic wr, input addr_t a, input data_t d,
                            output data_t exp_rd, output data_t rd);
        int waits;
        @(posedge clk);
        cyc   <= 1'b1;
        stb   <= 1'b1;
        we    <= wr;
        adr   <= a;
        dat_w <= d;
        waits = 0;
        do begin
            @(negedge clk);
            waits++;
            if (waits == 1)
                exp_rd = expected_read(a); // State the DUT samples next edge
        end while (!ack);
        rd = dat_r;
        assert (waits == 2) else begin
            $display("ack in %s came %0d cycles after the request, not 1", test_name, waits - 1);
            stop_on_error();
        end
    endtask

    task automatic release_bus();
        @(posedge clk);
        cyc <= 1'b0;
        stb <= 1'b0;
        we  <= 1'b0;
    endtask

    task automatic wb_write(input addr_t a, input data_t d);
        data_t exp_rd;
        data_t rd;
        wb_cycle(1'b1, a, d, exp_rd, rd);
        apply_write(a, d); // Write lands on the ack edge
        release_bus();
    endtask

    task automatic wb_read(input addr_t a);
        data_t exp_rd;
        data_t rd;
        wb_cycle(1'b0, a, '0, exp_rd, rd);
        assert (rd == exp_rd) else begin
            $display("mismatch %s expected %h actual %h", test_name, exp_rd, rd);
            stop_on_error();
        end
        last_rd = rd;
        release_bus();
    endtask

    initial begin
        cyc       = 1'b0;
        stb       = 1'b0;
        we        = 1'b0;
        adr       = '0;
        dat_w     = '0;
        rst_n     = 1'b0;
        exp_rst   = 4'b1000; // Only DMA 0 lacks bootstrap
        exp_pause = 4'b1000;
        exp_boot  = `SYSCFG_BOOT_ADDR_RST;
        cpu_mask  = '0;
        dma_mask  = '0;
        repeat (RST_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        repeat (2) @(posedge clk);

        test_name = "ctrl";
        for (int t = 0; t < `SYSCFG_NO_TGTS; t++) begin
            for (int v = 0; v < 4; v++) begin
                wb_write(reg_addr(t, REG_CTRL), ($random(seed) & ~32'h3) | v);
                wb_read(reg_addr(t, REG_CTRL));
            end
            wb_write(reg_addr(t, REG_CTRL), '0);
        end

        test_name = "status";
        for (int t = 0; t < `SYSCFG_NO_TGTS; t++) begin
            // Repeat until one read lands before the model acknowledges
            do begin
                wb_write(reg_addr(t, REG_CTRL), '0);
                do @(negedge clk); while (tgt_pause_ack[t]);
                wb_write(reg_addr(t, REG_CTRL), 32'h2);
                wb_read(reg_addr(t, REG_STATUS));
            end while (last_rd[0]);
            do @(negedge clk); while (!tgt_pause_ack[t]);
            wb_read(reg_addr(t, REG_STATUS));
            wb_write(reg_addr(t, REG_STATUS), '1);
            wb_write(reg_addr(t, REG_CTRL), '0);
            do @(negedge clk); while (tgt_pause_ack[t]);
            wb_read(reg_addr(t, REG_STATUS));
        end

        test_name = "boot";
        wb_write(reg_addr(`SYSCFG_TGT_CPU0, REG_BOOT), $random(seed));
        wb_read(reg_addr(`SYSCFG_TGT_CPU0, REG_BOOT));
        wb_write(reg_addr(`SYSCFG_TGT_LSDOM, REG_BOOT), $random(seed));
        wb_read(reg_addr(`SYSCFG_TGT_LSDOM, REG_BOOT));

        test_name = "irq";
        for (int r = 0; r < IRQ_ROUNDS; r++) begin
            wb_write(reg_addr(`SYSCFG_TGT_CPU0, REG_IRQ_MASK), sparse_word());
            wb_write(reg_addr(`SYSCFG_TGT_DMA0, REG_IRQ_MASK), sparse_word());
            wb_write(reg_addr(`SYSCFG_TGT_LSDOM, REG_IRQ_MASK), $random(seed));
            for (int t = 0; t < `SYSCFG_NO_TGTS; t++)
                wb_read(reg_addr(t, REG_IRQ_MASK));
            repeat (4) @(posedge clk);
        end

        test_name = "unmapped";
        for (int t = `SYSCFG_NO_TGTS; t < 8; t++) begin
            wb_write(reg_addr(t, reg_off_t'(t[1:0])), $random(seed));
            wb_read(reg_addr(t, reg_off_t'(t[1:0])));
        end

        repeat (2) @(posedge clk);
        $display("Test completed successfully");
        $finish;
    end

endmodule

// ==== syscfg_top.sv ====
`include "syscfg_consts.svh"
`timescale 1ns/1ps

module syscfg_top
    import syscfg_bus_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst_n,

    input  logic                       cyc,
    input  logic                       stb,
    input  logic                       we,
    input  addr_t                      adr,
    input  data_t                      dat_w,
    output data_t                      dat_r,
    output logic                       ack,

    input  data_t                      irq_vec,
    input  logic [`SYSCFG_NO_TGTS-1:0] tgt_pause_ack,

    output logic [`SYSCFG_NO_TGTS-1:0] tgt_rst,
    output logic [`SYSCFG_NO_TGTS-1:0] tgt_pause_req,
    output addr_t                      cpu_boot_addr,
    output logic                       cpu_irq,
    output logic                       dma_irq
);

    syscfg_reg_if tgt_bus [`SYSCFG_NO_TGTS] ();

    syscfg_wb_decoder decoder (
        .clk     (clk),
        .rst_n   (rst_n),
        .cyc     (cyc),
        .stb     (stb),
        .we      (we),
        .adr     (adr),
        .dat_w   (dat_w),
        .dat_r   (dat_r),
        .ack     (ack),
        .tgt_bus (tgt_bus)
    );

    syscfg_tgt #(
        .EN_BOOTSTRAP (1),
        .EN_BOOT_ADDR (0),
        .EN_IRQ       (0)
    ) tgt_lsdom (
        .clk       (clk),
        .rst_n     (rst_n),
        .bus       (tgt_bus[`SYSCFG_TGT_LSDOM]),
        .irq_vec   (irq_vec),
        .pause_ack (tgt_pause_ack[`SYSCFG_TGT_LSDOM]),
        .tgt_rst   (tgt_rst[`SYSCFG_TGT_LSDOM]),
        .pause_req (tgt_pause_req[`SYSCFG_TGT_LSDOM]),
        .boot_addr (),
        .irq       ()
    );

    syscfg_tgt #(
        .EN_BOOTSTRAP (1),
        .EN_BOOT_ADDR (0),
        .EN_IRQ       (0)
    ) tgt_hsdom (
        .clk       (clk),
        .rst_n     (rst_n),
        .bus       (tgt_bus[`SYSCFG_TGT_HSDOM]),
        .irq_vec   (irq_vec),
        .pause_ack (tgt_pause_ack[`SYSCFG_TGT_HSDOM]),
        .tgt_rst   (tgt_rst[`SYSCFG_TGT_HSDOM]),
        .pause_req (tgt_pause_req[`SYSCFG_TGT_HSDOM]),
        .boot_addr (),
        .irq       ()
    );

    syscfg_tgt #(
        .EN_BOOTSTRAP (1),
        .EN_BOOT_ADDR (1),
        .EN_IRQ       (1)
    ) tgt_cpu0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .bus       (tgt_bus[`SYSCFG_TGT_CPU0]),
        .irq_vec   (irq_vec),
        .pause_ack (tgt_pause_ack[`SYSCFG_TGT_CPU0]),
        .tgt_rst   (tgt_rst[`SYSCFG_TGT_CPU0]),
        .pause_req (tgt_pause_req[`SYSCFG_TGT_CPU0]),
        .boot_addr (cpu_boot_addr),
        .irq       (cpu_irq)
    );

    // Stays in reset until software releases it
    syscfg_tgt #(
        .EN_BOOTSTRAP (0),
        .EN_BOOT_ADDR (0),
        .EN_IRQ       (1)
    ) tgt_dma0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .bus       (tgt_bus[`SYSCFG_TGT_DMA0]),
        .irq_vec   (irq_vec),
        .pause_ack (tgt_pause_ack[`SYSCFG_TGT_DMA0]),
        .tgt_rst   (tgt_rst[`SYSCFG_TGT_DMA0]),
        .pause_req (tgt_pause_req[`SYSCFG_TGT_DMA0]),
        .boot_addr (),
        .irq       (dma_irq)
    );

endmodule

// ==== syscfg_tgt.sv ====
`include "syscfg_consts.svh"
`timescale 1ns/1ps

module syscfg_tgt
    import syscfg_bus_pkg::*;
    import syscfg_tgt_pkg::*;
#(
    parameter bit EN_BOOTSTRAP = 0,
    parameter bit EN_BOOT_ADDR = 0,
    parameter bit EN_IRQ       = 0
) (
    input  logic  clk,
    input  logic  rst_n,

    syscfg_reg_if.tgt bus,

    input  data_t irq_vec,
    input  logic  pause_ack,

    output logic  tgt_rst,
    output logic  pause_req,
    output addr_t boot_addr,
    output logic  irq
);

    // Bootstrap targets come out of reset running
    localparam tgt_ctrl_t CTRL_RST = EN_BOOTSTRAP ? `SYSCFG_CTRL_RST_RUN
                                                  : `SYSCFG_CTRL_RST_HOLD;

    tgt_ctrl_t ctrl;
    tgt_ctrl_t wr_ctrl;
    addr_t     boot_q;
    data_t     irq_mask;
    data_t     status;
    logic      wr;

    assign wr      = bus.sel && bus.we;
    assign wr_ctrl = tgt_ctrl_t'(bus.wdata);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ctrl <= CTRL_RST;
        end
        else if (wr && (bus.off == REG_CTRL)) begin
            ctrl.rst   <= wr_ctrl.rst;
            ctrl.pause <= wr_ctrl.pause;
            ctrl.rsvd  <= '0;
        end
    end

    generate
        if (EN_BOOT_ADDR) begin : g_boot
            always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                    boot_q <= `SYSCFG_BOOT_ADDR_RST;
                end
                else if (wr && (bus.off == REG_BOOT)) begin
                    boot_q <= addr_t'(bus.wdata);
                end
            end
        end
        else begin : g_no_boot
            assign boot_q = `SYSCFG_BOOT_ADDR_RST; // Fixed, reads back 0
        end

        if (EN_IRQ) begin : g_irq
            always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                    irq_mask <= '0;
                end
                else if (wr && (bus.off == REG_IRQ_MASK)) begin
                    irq_mask <= bus.wdata;
                end
            end
        end
        else begin : g_no_irq
            assign irq_mask = '0;
        end
    endgenerate

    // Paused only once the target has acknowledged
    always_comb begin
        status    = '0;
        status[0] = pause_req && pause_ack;
    end

    always_comb begin
        case (bus.off)
            REG_CTRL:     bus.rdata = data_t'(ctrl);
            REG_STATUS:   bus.rdata = status;
            REG_BOOT:     bus.rdata = EN_BOOT_ADDR ? data_t'(boot_q) : '0;
            REG_IRQ_MASK: bus.rdata = irq_mask;
            default:      bus.rdata = '0;
        endcase
    end

    assign tgt_rst   = ctrl.rst;
    assign pause_req = ctrl.pause;
    assign boot_addr = boot_q;
    assign irq       = |(irq_vec & irq_mask); // Same cycle as irq_vec

endmodule

// ==== syscfg_wb_decoder.sv ====
`include "syscfg_consts.svh"
`timescale 1ns/1ps

module syscfg_wb_decoder
    import syscfg_bus_pkg::*;
    import syscfg_tgt_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,

    // Wishbone classic slave
    input  logic  cyc,
    input  logic  stb,
    input  logic  we,
    input  addr_t adr,
    input  data_t dat_w,
    output data_t dat_r,
    output logic  ack,

    syscfg_reg_if.decoder tgt_bus [`SYSCFG_NO_TGTS]
);

    logic     req;
    tgt_idx_t idx;
    reg_off_t off;
    data_t    rdata [`SYSCFG_NO_TGTS];
    data_t    rdata_sel;

    // Master holds until ack, so a request is only taken while ack is low
    assign req = cyc && stb && !ack;

    assign idx = tgt_idx_t'(adr[`SYSCFG_TGT_LSB +: `SYSCFG_TGT_W]);
    assign off = reg_off_t'(adr[`SYSCFG_OFF_LSB +: `SYSCFG_OFF_W]);

    generate
        for (genvar i = 0; i < `SYSCFG_NO_TGTS; i++) begin : g_tgt
            // Target write lands on the same edge that raises ack
            assign tgt_bus[i].sel   = req && (idx == tgt_idx_t'(i));
            assign tgt_bus[i].we    = we;
            assign tgt_bus[i].off   = off;
            assign tgt_bus[i].wdata = dat_w;

            assign rdata[i] = tgt_bus[i].rdata;
        end
    endgenerate

    // Slots 4 to 7 fall through and read zero
    always_comb begin
        rdata_sel = '0;
        for (int i = 0; i < `SYSCFG_NO_TGTS; i++) begin
            if (idx == tgt_idx_t'(i)) begin
                rdata_sel = rdata[i];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ack <= 1'b0;
        end
        else begin
            ack <= req; // Single cycle, req drops while ack is high
        end
    end

    // Read data valid during ack
    always_ff @(posedge clk) begin
        if (req) begin
            dat_r <= rdata_sel;
        end
    end

endmodule

// ==== syscfg_reg_if.sv ====
`timescale 1ns/1ps

// One register access, decoder to a single target
interface syscfg_reg_if
    import syscfg_bus_pkg::*;
();

    logic     sel;   // One cycle, addressed target only
    logic     we;
    reg_off_t off;
    data_t    wdata;
    data_t    rdata; // Combinational from the target registers

    modport decoder (
        output sel,
        output we,
        output off,
        output wdata,
        input  rdata
    );

    modport tgt (
        input  sel,
        input  we,
        input  off,
        input  wdata,
        output rdata
    );

endinterface

// ==== syscfg_tgt_pkg.sv ====
`include "syscfg_consts.svh"

package syscfg_tgt_pkg;

    // CTRL register layout
    typedef struct packed {
        logic [`SYSCFG_DATA_W-3:0] rsvd;  // Reads zero
        logic                      pause; // 1 requests a pause
        logic                      rst;   // 1 holds the target in reset
    } tgt_ctrl_t;

    // Target slot as decoded from the address
    typedef logic [`SYSCFG_TGT_W-1:0] tgt_idx_t;

endpackage

// ==== syscfg_bus_pkg.sv ====
`include "syscfg_consts.svh"

package syscfg_bus_pkg;

    // Full byte address, only bits 6:2 are decoded
    typedef logic [`SYSCFG_ADDR_W-1:0] addr_t;

    typedef logic [`SYSCFG_DATA_W-1:0] data_t;

    // Register slot within one target block
    typedef enum logic [`SYSCFG_OFF_W-1:0] {
        REG_CTRL     = `SYSCFG_REG_CTRL,
        REG_STATUS   = `SYSCFG_REG_STATUS,
        REG_BOOT     = `SYSCFG_REG_BOOT,
        REG_IRQ_MASK = `SYSCFG_REG_IRQ_MASK
    } reg_off_t;

endpackage

// ==== syscfg_consts.svh ====
`ifndef SYSCFG_CONSTS_SVH
`define SYSCFG_CONSTS_SVH

`define SYSCFG_DATA_W  32
`define SYSCFG_ADDR_W  32
`define SYSCFG_NO_TGTS 4
`define SYSCFG_TGT_W   3  // Up to 8 target slots
`define SYSCFG_OFF_W   2

// Field positions in the byte address
`define SYSCFG_OFF_LSB 2
`define SYSCFG_TGT_LSB 4

`define SYSCFG_TGT_LSDOM 0
`define SYSCFG_TGT_HSDOM 1
`define SYSCFG_TGT_CPU0  2
`define SYSCFG_TGT_DMA0  3

`define SYSCFG_REG_CTRL     2'd0
`define SYSCFG_REG_STATUS   2'd1
`define SYSCFG_REG_BOOT     2'd2
`define SYSCFG_REG_IRQ_MASK 2'd3

`define SYSCFG_BOOT_ADDR_RST 32'h0000_1000
`define SYSCFG_CTRL_RST_RUN  32'h0000_0000  // Bootstrap target, running
`define SYSCFG_CTRL_RST_HOLD 32'h0000_0003  // Held in reset and paused

`endif
